// ==== Bender.yml ====
package:
  name: md5_core

sources:
  - files:
      - rtl/md5Pkg.sv
      - rtl/md5Step.sv
      - rtl/md5Core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/md5CoreTb.sv

// ==== rtl/md5Core.sv ====
// Pipelined MD5 compression core
// Accepts one chunk and initial state per clock and returns the state after
// all 64 steps exactly 64 cycles later, without feed-forward
module md5Core import md5Pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  validIn,
  input  chunkT chunkIn,
  input  stateT ivIn,
  output stateT stateOut,
  output logic  validOut
);

  // stages[k] feeds step k, stages[NumSteps] is the final result
  stageT stages [NumSteps+1];

  assign stages[0] = '{valid: validIn, state: ivIn, chunk: chunkIn};

  for (genvar k = 0; k < NumSteps; k++) begin : gStep
    md5Step #(
      .Step(k)
    ) i_step (
      .clk     (clk),
      .reset   (reset),
      .stageIn (stages[k]),
      .stageOut(stages[k+1])
    );
  end

  assign stateOut = stages[NumSteps].state;  // Only meaningful with validOut
  assign validOut = stages[NumSteps].valid;

endmodule

// ==== rtl/md5Pkg.sv ====
// MD5 core package
// Word, chunk, state and stage types, plus the per-step constant tables
// for the round function, the sine constants, the rotate amounts and the
// message word order
package md5Pkg;

  localparam int WordWidth  = 32;
  localparam int ChunkWords = 16;
  localparam int NumSteps   = 64;

  typedef logic [WordWidth-1:0] wordT;

  // Word i sits at bits 32i up to 32i+31
  typedef wordT [ChunkWords-1:0] chunkT;

  typedef struct packed {
    wordT a;
    wordT b;
    wordT c;
    wordT d;
  } stateT;

  // Record handed from one pipeline step to the next
  typedef struct packed {
    logic  valid;
    stateT state;
    chunkT chunk;
  } stageT;

  typedef enum logic [1:0] {
    funcF = 2'd0,  // (b & c) | (~b & d)
    funcG = 2'd1,  // (d & b) | (~d & c)
    funcH = 2'd2,  // b ^ c ^ d
    funcI = 2'd3   // c ^ (b | ~d)
  } roundFuncE;

  // Rotate amounts, four per round, repeated over the 16 steps of a round
  localparam int unsigned ShiftTable [4][4] = '{
    '{7, 12, 17, 22},
    '{5, 9, 14, 20},
    '{4, 11, 16, 23},
    '{6, 10, 15, 21}
  };

  // Each round covers 16 consecutive steps
  function automatic roundFuncE roundOf(int unsigned step);
    return roundFuncE'(step / 16);
  endfunction

  function automatic int unsigned shiftOf(int unsigned step);
    return ShiftTable[step / 16][step % 4];
  endfunction

  // Chunk word used by each step
  function automatic int unsigned msgIndexOf(int unsigned step);
    int unsigned idx;
    case (roundOf(step))
      funcF:   idx = step % 16;
      funcG:   idx = (5 * step + 1) % 16;
      funcH:   idx = (3 * step + 5) % 16;
      default: idx = (7 * step) % 16;
    endcase
    return idx;
  endfunction

  // floor(abs(sin(i + 1)) * 2^32)
  function automatic wordT sineConst(int unsigned step);
    case (step)
      0:  return 32'hd76aa478;
      1:  return 32'he8c7b756;
      2:  return 32'h242070db;
      3:  return 32'hc1bdceee;
      4:  return 32'hf57c0faf;
      5:  return 32'h4787c62a;
      6:  return 32'ha8304613;
      7:  return 32'hfd469501;
      8:  return 32'h698098d8;
      9:  return 32'h8b44f7af;
      10: return 32'hffff5bb1;
      11: return 32'h895cd7be;
      12: return 32'h6b901122;
      13: return 32'hfd987193;
      14: return 32'ha679438e;
      15: return 32'h49b40821;
      16: return 32'hf61e2562;
      17: return 32'hc040b340;
      18: return 32'h265e5a51;
      19: return 32'he9b6c7aa;
      20: return 32'hd62f105d;
      21: return 32'h02441453;
      22: return 32'hd8a1e681;
      23: return 32'he7d3fbc8;
      24: return 32'h21e1cde6;
      25: return 32'hc33707d6;
      26: return 32'hf4d50d87;
      27: return 32'h455a14ed;
      28: return 32'ha9e3e905;
      29: return 32'hfcefa3f8;
      30: return 32'h676f02d9;
      31: return 32'h8d2a4c8a;
      32: return 32'hfffa3942;
      33: return 32'h8771f681;
      34: return 32'h6d9d6122;
      35: return 32'hfde5380c;
      36: return 32'ha4beea44;
      37: return 32'h4bdecfa9;
      38: return 32'hf6bb4b60;
      39: return 32'hbebfbc70;
      40: return 32'h289b7ec6;
      41: return 32'heaa127fa;
      42: return 32'hd4ef3085;
      43: return 32'h04881d05;
      44: return 32'hd9d4d039;
      45: return 32'he6db99e5;
      46: return 32'h1fa27cf8;
      47: return 32'hc4ac5665;
      48: return 32'hf4292244;
      49: return 32'h432aff97;
      50: return 32'hab9423a7;
      51: return 32'hfc93a039;
      52: return 32'h655b59c3;
      53: return 32'h8f0ccc92;
      54: return 32'hffeff47d;
      55: return 32'h85845dd1;
      56: return 32'h6fa87e4f;
      57: return 32'hfe2ce6e0;
      58: return 32'ha3014314;
      59: return 32'h4e0811a1;
      60: return 32'hf7537e82;
      61: return 32'hbd3af235;
      62: return 32'h2ad7d2bb;
      63: return 32'heb86d391;
      default: return '0;
    endcase
  endfunction

endpackage

// ==== rtl/md5Step.sv ====
// One MD5 step as a single pipeline stage
// The step index picks the round function, constant, rotate amount and
// chunk word at elaboration; the chunk rides along unchanged
module md5Step import md5Pkg::*; #(
  parameter int unsigned Step = 0
) (
  input  logic  clk,
  input  logic  reset,
  input  stageT stageIn,
  output stageT stageOut
);

  localparam roundFuncE   Func   = roundOf(Step);
  localparam wordT        K      = sineConst(Step);
  localparam int unsigned Shift  = shiftOf(Step);
  localparam int unsigned MsgIdx = msgIndexOf(Step);

  wordT a;
  wordT b;
  wordT c;
  wordT d;
  wordT msgWord;
  wordT funcOut;
  wordT sum;
  wordT rotated;
  wordT newB;

  logic  validQ;
  stateT stateQ;
  chunkT chunkQ;

  assign a       = stageIn.state.a;
  assign b       = stageIn.state.b;
  assign c       = stageIn.state.c;
  assign d       = stageIn.state.d;
  assign msgWord = stageIn.chunk[MsgIdx];

  always_comb begin
    unique case (Func)
      funcF: funcOut = (b & c) | (~b & d);
      funcG: funcOut = (d & b) | (~d & c);
      funcH: funcOut = b ^ c ^ d;
      funcI: funcOut = c ^ (b | ~d);
    endcase
  end

  assign sum     = a + funcOut + K + msgWord;
  assign rotated = (sum << Shift) | (sum >> (WordWidth - Shift));  // Rotate left
  assign newB    = b + rotated;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validQ <= 1'b0;
    end else begin
      validQ <= stageIn.valid;
    end
  end

  // State words shift one place, b takes the new sum
  always_ff @(posedge clk) begin
    stateQ.a <= d;
    stateQ.b <= newB;
    stateQ.c <= b;
    stateQ.d <= c;
    chunkQ   <= stageIn.chunk;
  end

  assign stageOut = '{valid: validQ, state: stateQ, chunk: chunkQ};

endmodule

// ==== sim.f ====
+incdir+tb
rtl/md5Pkg.sv
rtl/md5Step.sv
rtl/md5Core.sv
tb/md5CoreTb.sv

// ==== tb/md5Model.svh ====
// MD5 reference model for the testbench
// Computes the 64 compression steps from first principles and provides
// the linear congruential generator for random stimulus
`ifndef MD5_MODEL_SVH
`define MD5_MODEL_SVH

// Rotate amounts, indexed by round * 4 + step % 4
localparam int unsigned RotTable [16] = '{
  7, 12, 17, 22,
  5, 9, 14, 20,
  4, 11, 16, 23,
  6, 10, 15, 21
};

// Message word index is (mult * step + offset) mod 16 per round
localparam int unsigned IdxMult [4]   = '{1, 5, 3, 7};
localparam int unsigned IdxOffset [4] = '{0, 1, 5, 0};

logic [31:0] randState = 32'h3eafdd62;

function automatic logic [31:0] rotl(logic [31:0] x, int unsigned n);
  return (x << n) | (x >> (32 - n));
endfunction

// floor(|sin(i + 1)| * 2^32)
function automatic logic [31:0] sineOf(int unsigned i);
  real s;
  longint v;
  s = $sin(real'(i + 1));
  if (s < 0.0) begin
    s = -s;
  end
  v = longint'($floor(s * 4294967296.0));
  return v[31:0];
endfunction

function automatic stateT md5Steps(chunkT chunk, stateT iv);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] c;
  logic [31:0] d;
  logic [31:0] f;
  logic [31:0] tmp;
  int unsigned r;
  int unsigned g;
  stateT res;
  a = iv.a;
  b = iv.b;
  c = iv.c;
  d = iv.d;
  for (int unsigned i = 0; i < 64; i++) begin
    r = i / 16;
    case (r)
      0:       f = (b & c) | (~b & d);
      1:       f = (d & b) | (~d & c);
      2:       f = b ^ c ^ d;
      default: f = c ^ (b | ~d);
    endcase
    g   = (IdxMult[r] * i + IdxOffset[r]) % 16;
    tmp = a + f + sineOf(i) + chunk[g];
    a   = d;
    d   = c;
    c   = b;
    b   = b + rotl(tmp, RotTable[r * 4 + i % 4]);
  end
  res.a = a;
  res.b = b;
  res.c = c;
  res.d = d;
  return res;
endfunction

// Numerical Recipes constants
function automatic logic [31:0] nextRand();
  randState = randState * 32'd1664525 + 32'd1013904223;
  return randState;
endfunction

function automatic chunkT randChunk();
  chunkT ch;
  for (int i = 0; i < 16; i++) begin
    ch[i] = nextRand();
  end
  return ch;
endfunction

function automatic stateT randState4();
  stateT s;
  s.a = nextRand();
  s.b = nextRand();
  s.c = nextRand();
  s.d = nextRand();
  return s;
endfunction

`endif

// ==== tb/md5CoreTb.sv ====
// Testbench for the pipelined MD5 core
// Drives idle, known-answer, back-to-back, gapped and reset-in-flight traffic
// and checks every output against the reference model and its latency
module md5CoreTb import md5Pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int Latency = 64;

  logic  clk;
  logic  reset;
  logic  validIn;
  chunkT chunkIn;
  stateT ivIn;
  stateT stateOut;
  logic  validOut;

  stateT       expQ [$];
  int unsigned dueQ [$];
  int unsigned edgeCount;
  int unsigned inCount;
  int unsigned outCount;
  int          errors;
  int          checks;

  `include "md5Model.svh"

  md5Core i_dut (
    .clk     (clk),
    .reset   (reset),
    .validIn (validIn),
    .chunkIn (chunkIn),
    .ivIn    (ivIn),
    .stateOut(stateOut),
    .validOut(validOut)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    edgeCount <= edgeCount + 1;
  end

  task automatic checkValue(logic [127:0] got, logic [127:0] exp, string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic finishRun();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  function automatic wordT byteSwap(wordT w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Outputs and inputs are both stable at the falling edge
  always @(negedge clk) begin
    stateT       exp;
    int unsigned due;
    if (reset) begin
      expQ.delete();  // In-flight items are lost
      dueQ.delete();
    end else begin
      if (validOut) begin
        outCount++;
        if (expQ.size() == 0) begin
          errors++;
          $display("At %0t ns validOut was high with no item in flight", $time);
        end else begin
          exp = expQ.pop_front();
          due = dueQ.pop_front();
          checkValue(stateOut, exp, "stateOut");
          checkValue(128'(edgeCount), 128'(due), "output cycle");
        end
      end
      if (validIn) begin
        expQ.push_back(md5Steps(chunkIn, ivIn));
        dueQ.push_back(edgeCount + Latency);
        inCount++;
      end
    end
  end

  task automatic driveItem(chunkT ch, stateT iv);
    @(posedge clk);
    #10;
    validIn = 1'b1;
    chunkIn = ch;
    ivIn    = iv;
  endtask

  task automatic driveIdle(int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      #10;
      validIn = 1'b0;
      chunkIn = randChunk();  // Garbage data must not matter
      ivIn    = randState4();
    end
  endtask

  // Wait until every inserted item has come out
  task automatic waitDrain(int limit, string what);
    int cnt;
    cnt = 0;
    while (expQ.size() != 0) begin
      @(posedge clk);
      cnt++;
      if (cnt > limit) begin
        errors++;
        $display("Timeout: %s still had %0d results outstanding", what, expQ.size());
        finishRun();
      end
    end
  endtask

  task automatic waitValid(int limit, string what);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!validOut) begin
      @(negedge clk);
      cnt++;
      if (cnt > limit) begin
        errors++;
        $display("Timeout: no validOut seen for %s", what);
        finishRun();
      end
    end
  endtask

  initial begin
    chunkT       ch;
    stateT       std;
    logic [127:0] digest;
    int          sent;
    int unsigned inBase;
    int unsigned outBase;

    clk       = 1'b0;
    reset     = 1'b1;
    validIn   = 1'b0;
    chunkIn   = '0;
    ivIn      = '0;
    edgeCount = 0;
    inCount   = 0;
    outCount  = 0;
    errors    = 0;
    checks    = 0;

    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;

    // Idle pipeline stays quiet
    driveIdle(80);

    // Known answer for the empty message
    std.a = 32'h67452301;
    std.b = 32'hefcdab89;
    std.c = 32'h98badcfe;
    std.d = 32'h10325476;
    ch    = '0;
    ch[0] = 32'h00000080;
    driveItem(ch, std);
    driveIdle(1);
    waitValid(Latency + 10, "known answer");
    digest = {byteSwap(stateOut.a + std.a), byteSwap(stateOut.b + std.b),
              byteSwap(stateOut.c + std.c), byteSwap(stateOut.d + std.d)};
    checkValue(digest, 128'hd41d8cd98f00b204e9800998ecf8427e, "empty message digest");
    waitDrain(Latency + 10, "known answer");

    // Back-to-back random traffic
    for (int i = 0; i < 200; i++) begin
      driveItem(randChunk(), randState4());
    end
    driveIdle(1);
    waitDrain(Latency + 10, "back-to-back traffic");

    // Gapped random traffic
    inBase  = inCount;
    outBase = outCount;
    sent    = 0;
    for (int cyc = 0; cyc < 2000 && sent < 100; cyc++) begin
      if (nextRand() >= 32'h80000000) begin
        driveItem(randChunk(), randState4());
        sent++;
      end else begin
        driveIdle(1);
      end
    end
    driveIdle(1);
    if (sent != 100) begin
      errors++;
      $display("Only %0d of 100 gapped items could be sent", sent);
    end
    waitDrain(Latency + 10, "gapped traffic");
    checkValue(128'(inCount - inBase), 128'd100, "gapped inputs");
    checkValue(128'(outCount - outBase), 128'(inCount - inBase), "gapped output count");

    // Reset with items in flight
    for (int i = 0; i < 30; i++) begin
      driveItem(randChunk(), randState4());
    end
    @(posedge clk);
    #10;
    validIn = 1'b0;
    reset   = 1'b1;
    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;
    driveIdle(70);
    inBase  = inCount;
    outBase = outCount;
    driveItem(randChunk(), randState4());
    driveIdle(1);
    waitDrain(Latency + 10, "item after reset");
    checkValue(128'(outCount - outBase), 128'd1, "outputs after reset");
    driveIdle(5);

    finishRun();
  end

endmodule
